/* Makefile */
# verilator build and run for the beam display testbench

SIM := obj_dir/beam_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wall -f build.f --top-module beam_tb -o beam_sim
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* build.f */
hdl/beam_pkg.sv
hdl/screen_pos_if.sv
hdl/display_timings.sv
hdl/square_mover.sv
hdl/beam_painter.sv
hdl/beam_top.sv
tests/tb_clock.sv
tests/beam_assert.sv
tests/beam_tb.sv

/* hdl/beam_painter.sv */
// pixel colour for the moving square
// hit test, colour select, registered vga syncs and channels

module beam_painter #(
    parameter int Q_SIZE = beam_pkg::DEF_Q_SIZE
) (
    input  logic             clk_pix,
    input  logic             rst_n,
    screen_pos_if.sink       scr,
    input  beam_pkg::coord_t qx,
    input  beam_pkg::coord_t qy,
    output logic             vga_hsync,
    output logic             vga_vsync,
    output beam_pkg::chan_t  vga_r,
    output beam_pkg::chan_t  vga_g,
    output beam_pkg::chan_t  vga_b
);

    localparam beam_pkg::coord_t Q_SZ = beam_pkg::coord_t'(Q_SIZE);

    logic            q_hit;  // beam inside the square
    beam_pkg::chan_t r_d;
    beam_pkg::chan_t g_d;
    beam_pkg::chan_t b_d;

    // half-open box [q, q+size) on both axes
    always_comb begin
        q_hit = (scr.sx >= qx) && (scr.sx < qx + Q_SZ)
             && (scr.sy >= qy) && (scr.sy < qy + Q_SZ);
    end

    // colour rule
    always_comb begin
        if (!scr.de) begin
            r_d = 4'h0;  // blanking is black
            g_d = 4'h0;
            b_d = 4'h0;
        end else if (q_hit) begin
            r_d = 4'hF;  // orange
            g_d = 4'h8;
            b_d = 4'h0;
        end else begin
            r_d = 4'h0;  // background blue
            g_d = 4'h8;
            b_d = 4'hF;
        end
    end

    // one register stage, syncs kept aligned with colour
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= scr.hsync_raw;
            vga_vsync <= scr.vsync_raw;
            vga_r     <= r_d;
            vga_g     <= g_d;
            vga_b     <= b_d;
        end
    end

endmodule

/* hdl/beam_pkg.sv */
// shared types for the beam display
// coordinate and colour-channel typedefs, default 640x480 geometry

package beam_pkg;

    // screen coordinate, pixels or lines
    typedef logic [9:0] coord_t;

    // one colour channel, 4-bit vga dac
    typedef logic [3:0] chan_t;

    // horizontal defaults in pixels
    localparam int DEF_H_RES  = 640;  // active
    localparam int DEF_H_FP   = 16;   // front porch
    localparam int DEF_H_SYNC = 96;   // sync pulse
    localparam int DEF_H_BP   = 48;   // back porch

    // vertical defaults in lines
    localparam int DEF_V_RES  = 480;  // active
    localparam int DEF_V_FP   = 10;   // front porch
    localparam int DEF_V_SYNC = 2;    // sync pulse
    localparam int DEF_V_BP   = 33;   // back porch

    // moving square
    localparam int DEF_Q_SIZE  = 32;  // side in pixels
    localparam int DEF_Q_SPEED = 4;   // pixels per frame

endpackage

/* hdl/beam_top.sv */
// beam display top level
// timing generator, square mover and painter on plain vga ports

module beam_top #(
    parameter int H_RES   = beam_pkg::DEF_H_RES,
    parameter int H_FP    = beam_pkg::DEF_H_FP,
    parameter int H_SYNC  = beam_pkg::DEF_H_SYNC,
    parameter int H_BP    = beam_pkg::DEF_H_BP,
    parameter int V_RES   = beam_pkg::DEF_V_RES,
    parameter int V_FP    = beam_pkg::DEF_V_FP,
    parameter int V_SYNC  = beam_pkg::DEF_V_SYNC,
    parameter int V_BP    = beam_pkg::DEF_V_BP,
    parameter int Q_SIZE  = beam_pkg::DEF_Q_SIZE,
    parameter int Q_SPEED = beam_pkg::DEF_Q_SPEED
) (
    input  logic            clk_pix,    // pixel clock
    input  logic            rst_n,
    output logic            vga_hsync,  // active low
    output logic            vga_vsync,  // active low
    output beam_pkg::chan_t vga_r,
    output beam_pkg::chan_t vga_g,
    output beam_pkg::chan_t vga_b
);

    screen_pos_if scr ();  // beam position bus

    beam_pkg::coord_t qx;  // square corner
    beam_pkg::coord_t qy;

    display_timings #(
        .H_RES (H_RES),  .H_FP (H_FP),  .H_SYNC (H_SYNC),  .H_BP (H_BP),
        .V_RES (V_RES),  .V_FP (V_FP),  .V_SYNC (V_SYNC),  .V_BP (V_BP)
    ) u_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .scr     (scr.source)
    );

    square_mover #(
        .H_RES (H_RES),  .H_FP (H_FP),  .H_SYNC (H_SYNC),  .H_BP (H_BP),
        .V_RES (V_RES),  .V_FP (V_FP),  .V_SYNC (V_SYNC),  .V_BP (V_BP),
        .Q_SIZE (Q_SIZE), .Q_SPEED (Q_SPEED)
    ) u_mover (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .scr     (scr.sink),
        .qx      (qx),
        .qy      (qy)
    );

    beam_painter #(
        .Q_SIZE (Q_SIZE)
    ) u_painter (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .scr       (scr.sink),
        .qx        (qx),
        .qy        (qy),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

/* hdl/display_timings.sv */
// raster timing generator
// pixel and line counters, sync / data-enable / frame-tick decode

module display_timings #(
    parameter int H_RES  = beam_pkg::DEF_H_RES,
    parameter int H_FP   = beam_pkg::DEF_H_FP,
    parameter int H_SYNC = beam_pkg::DEF_H_SYNC,
    parameter int H_BP   = beam_pkg::DEF_H_BP,
    parameter int V_RES  = beam_pkg::DEF_V_RES,
    parameter int V_FP   = beam_pkg::DEF_V_FP,
    parameter int V_SYNC = beam_pkg::DEF_V_SYNC,
    parameter int V_BP   = beam_pkg::DEF_V_BP
) (
    input  logic         clk_pix,
    input  logic         rst_n,
    screen_pos_if.source scr
);

    // full line and frame including blanking
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    localparam beam_pkg::coord_t H_LAST = beam_pkg::coord_t'(H_TOTAL - 1);
    localparam beam_pkg::coord_t V_LAST = beam_pkg::coord_t'(V_TOTAL - 1);

    // sync windows, start at res+fp
    localparam beam_pkg::coord_t HS_START = beam_pkg::coord_t'(H_RES + H_FP);
    localparam beam_pkg::coord_t HS_END   = beam_pkg::coord_t'(H_RES + H_FP + H_SYNC);
    localparam beam_pkg::coord_t VS_START = beam_pkg::coord_t'(V_RES + V_FP);
    localparam beam_pkg::coord_t VS_END   = beam_pkg::coord_t'(V_RES + V_FP + V_SYNC);

    localparam beam_pkg::coord_t H_ACT = beam_pkg::coord_t'(H_RES);
    localparam beam_pkg::coord_t V_ACT = beam_pkg::coord_t'(V_RES);

    beam_pkg::coord_t sx_q;
    beam_pkg::coord_t sy_q;
    logic             run;  // low until first edge after reset

    // first edge after release only arms the counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // beam counters, sx fastest
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx_q <= '0;
            sy_q <= '0;
        end else if (run) begin
            if (sx_q == H_LAST) begin  // end of line
                sx_q <= '0;
                sy_q <= (sy_q == V_LAST) ? '0 : sy_q + 1'b1;
            end else begin
                sx_q <= sx_q + 1'b1;
            end
        end
    end

    assign scr.sx = sx_q;
    assign scr.sy = sy_q;

    // decodes of the registered counters, valid alongside sx/sy
    always_comb begin
        scr.hsync_raw  = !((sx_q >= HS_START) && (sx_q < HS_END));
        scr.vsync_raw  = !((sy_q >= VS_START) && (sy_q < VS_END));
        // run keeps the held reset position out of active video
        scr.de         = run && (sx_q < H_ACT) && (sy_q < V_ACT);
        scr.frame_tick = (sy_q == V_ACT) && (sx_q == '0);  // first blank line
    end

endmodule

/* hdl/screen_pos_if.sv */
// beam position and timing levels
// driven by the timing generator, read by mover and painter

interface screen_pos_if;

    beam_pkg::coord_t sx;  // pixel counter
    beam_pkg::coord_t sy;  // line counter
    logic de;              // active video
    logic hsync_raw;       // active low
    logic vsync_raw;       // active low
    logic frame_tick;      // one cycle at start of vertical blank

    // timing generator side
    modport source (
        output sx, sy, de, hsync_raw, vsync_raw, frame_tick
    );

    // consumers of the beam position
    modport sink (
        input sx, sy, de, hsync_raw, vsync_raw, frame_tick
    );

endinterface

/* hdl/square_mover.sv */
// square position register
// steps the top-left corner once per frame, wraps at line and frame end

module square_mover #(
    parameter int H_RES   = beam_pkg::DEF_H_RES,
    parameter int H_FP    = beam_pkg::DEF_H_FP,
    parameter int H_SYNC  = beam_pkg::DEF_H_SYNC,
    parameter int H_BP    = beam_pkg::DEF_H_BP,
    parameter int V_RES   = beam_pkg::DEF_V_RES,
    parameter int V_FP    = beam_pkg::DEF_V_FP,
    parameter int V_SYNC  = beam_pkg::DEF_V_SYNC,
    parameter int V_BP    = beam_pkg::DEF_V_BP,
    parameter int Q_SIZE  = beam_pkg::DEF_Q_SIZE,
    parameter int Q_SPEED = beam_pkg::DEF_Q_SPEED
) (
    input  logic             clk_pix,
    input  logic             rst_n,
    screen_pos_if.sink       scr,
    output beam_pkg::coord_t qx,
    output beam_pkg::coord_t qy
);

    // full line and frame including blanking
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    // wrap thresholds, the square may run into blanking
    localparam beam_pkg::coord_t QX_WRAP = beam_pkg::coord_t'(H_TOTAL - Q_SIZE);
    localparam beam_pkg::coord_t QY_WRAP = beam_pkg::coord_t'(V_TOTAL - Q_SIZE);

    localparam beam_pkg::coord_t Q_STEP_X = beam_pkg::coord_t'(Q_SPEED);
    localparam beam_pkg::coord_t Q_STEP_Y = beam_pkg::coord_t'(Q_SIZE);

    beam_pkg::coord_t qx_next;
    beam_pkg::coord_t qy_next;

    // next corner, only taken on frame_tick
    always_comb begin
        qx_next = qx + Q_STEP_X;
        qy_next = qy;
        if (qx >= QX_WRAP) begin  // right edge reached
            qx_next = '0;
            // drop one row, or back to top
            qy_next = (qy >= QY_WRAP) ? '0 : qy + Q_STEP_Y;
        end
    end

    // update lands on the edge ending the tick cycle
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            qx <= '0;
            qy <= '0;
        end else if (scr.frame_tick) begin
            qx <= qx_next;
            qy <= qy_next;
        end
    end

endmodule

/* tests/beam_assert.sv */
// concurrent checks on painter outputs and timing levels
// bound into the top level, where both are visible

module beam_assert #(
    parameter int H_SYNC = 4
) (
    input logic            clk_pix,
    input logic            rst_n,
    input logic            de,
    input logic            frame_tick,
    input logic            hsync_raw,
    input beam_pkg::chan_t vga_r,
    input beam_pkg::chan_t vga_g,
    input beam_pkg::chan_t vga_b
);

    // blanking shows up black one cycle later
    a_blank_black: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |=> (vga_r == '0) && (vga_g == '0) && (vga_b == '0))
        else $error("colour not black after blanking");

    // single-cycle pulse
    a_tick_short: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_tick |=> !frame_tick)
        else $error("frame_tick longer than one cycle");

    // sync pulse width in pixels
    a_hsync_len: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(hsync_raw) |-> ##(H_SYNC - 1) !hsync_raw ##1 hsync_raw)
        else $error("hsync_raw pulse width wrong");

endmodule

bind beam_top beam_assert #(.H_SYNC(H_SYNC)) u_assert (
    .clk_pix    (clk_pix),
    .rst_n      (rst_n),
    .de         (scr.de),
    .frame_tick (scr.frame_tick),
    .hsync_raw  (scr.hsync_raw),
    .vga_r      (vga_r),
    .vga_g      (vga_g),
    .vga_b      (vga_b)
);

/* tests/beam_tb.sv */
// table-driven testbench for the beam display
// small screen, reference model of the square, sync and colour checks

module beam_tb;

    localparam int H_RES = 32, H_FP = 4, H_SYNC = 4, H_BP = 8;
    localparam int V_RES = 24, V_FP = 2, V_SYNC = 2, V_BP = 4;
    localparam int Q_SIZE = 8, Q_SPEED = 4;
    localparam int LINE_W = H_RES + H_FP + H_SYNC + H_BP;    // 48
    localparam int FRAME_H = V_RES + V_FP + V_SYNC + V_BP;   // 32
    localparam int FRAME_LEN = LINE_W * FRAME_H;            // cycles per frame

    logic            clk_pix;
    logic            rst_n;
    logic            vga_hsync;
    logic            vga_vsync;
    beam_pkg::chan_t vga_r;
    beam_pkg::chan_t vga_g;
    beam_pkg::chan_t vga_b;

    int    edge_cnt;     // rising edges since reset release
    bit    table_ready;
    string names[$];     // stimulus table columns
    int    frames[$];
    int    xs[$];
    int    ys[$];

    tb_clock #(.PERIOD(20)) u_clk (.clk_pix(clk_pix));

    beam_top #(
        .H_RES (H_RES), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
        .V_RES (V_RES), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
        .Q_SIZE (Q_SIZE), .Q_SPEED (Q_SPEED)
    ) u_dut (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    // output sample after edge n shows raster position n-2
    always @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) edge_cnt <= 0;
        else edge_cnt <= edge_cnt + 1;
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic add_entry(input string name, input int frame, input int x, input int y);
        names.push_back(name);
        frames.push_back(frame);
        xs.push_back(x);
        ys.push_back(y);
    endtask

    // reference colour, mover rules replayed frame by frame
    function automatic logic [11:0] expected_colour(input int frame, input int x, input int y);
        int qx;
        int qy;
        int f;
        qx = 0;
        qy = 0;
        for (f = 0; f < frame; f++) begin
            if (qx >= LINE_W - Q_SIZE) begin
                qx = 0;
                qy = (qy >= FRAME_H - Q_SIZE) ? 0 : qy + Q_SIZE;
            end else begin
                qx = qx + Q_SPEED;
            end
        end
        if (x >= H_RES || y >= V_RES) return 12'h000;  // blanking
        if (x >= qx && x < qx + Q_SIZE && y >= qy && y < qy + Q_SIZE) return 12'hF80;
        return 12'h08F;                                  // background
    endfunction

    // entries must be in raster order
    task automatic build_table();
        add_entry("f0_origin", 0, 0, 0);   add_entry("f0_q_edge", 0, 7, 0);
        add_entry("f0_q_out", 0, 8, 0);    add_entry("f0_last_act", 0, 31, 0);
        add_entry("f0_h_fp", 0, 32, 0);    add_entry("f0_hs_pre", 0, 35, 0);
        add_entry("f0_hs_first", 0, 36, 0);  add_entry("f0_hs_last", 0, 39, 0);
        add_entry("f0_hs_post", 0, 40, 0);   add_entry("f0_line_end", 0, 47, 0);
        add_entry("f0_q_corner", 0, 7, 7);   add_entry("f0_q_right", 0, 8, 7);
        add_entry("f0_q_below", 0, 0, 8);    add_entry("f0_last_line", 0, 10, 23);
        add_entry("f0_v_fp", 0, 5, 24);      add_entry("f0_vs_pre", 0, 5, 25);
        add_entry("f0_vs_first", 0, 5, 26);  add_entry("f0_vs_hs", 0, 37, 26);
        add_entry("f0_vs_last", 0, 5, 27);   add_entry("f0_vs_post", 0, 5, 28);
        add_entry("f0_frame_end", 0, 5, 31);
        add_entry("f1_left_out", 1, 3, 2);   add_entry("f1_left_in", 1, 4, 2);
        add_entry("f1_right_in", 1, 11, 2);  add_entry("f1_right_out", 1, 12, 2);
        add_entry("f5_left_out", 5, 19, 3);  add_entry("f5_left_in", 5, 20, 3);
        add_entry("f5_corner", 5, 27, 7);    add_entry("f5_corner_out", 5, 28, 7);
        add_entry("f7_edge_in", 7, 31, 0);   add_entry("f7_in_blank", 7, 32, 0);
        add_entry("f10_offscreen", 10, 31, 5);
        add_entry("f11_above", 11, 0, 7);    add_entry("f11_top", 11, 0, 8);
        add_entry("f11_bottom", 11, 7, 15);  add_entry("f11_below", 11, 7, 16);
        add_entry("f22_above", 22, 3, 15);   add_entry("f22_top", 22, 3, 16);
        add_entry("f22_bottom", 22, 3, 23);
        add_entry("f33_hidden", 33, 0, 23);
        add_entry("f44_wrapped", 44, 0, 0);  add_entry("f44_outside", 44, 8, 8);
        add_entry("f45_stepped", 45, 4, 0);
    endtask

    initial begin
        int          i;
        int          target;
        logic [11:0] exp_rgb;
        rst_n = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(negedge clk_pix);
        check_val("reset_hsync", 32'd1, 32'(vga_hsync));
        check_val("reset_vsync", 32'd1, 32'(vga_vsync));
        check_val("reset_rgb", 32'h0, 32'({vga_r, vga_g, vga_b}));
        rst_n = 1'b1;  // released on the falling edge
        @(negedge clk_pix);
        // first sample still shows the reset state
        check_val("first_hsync", 32'd1, 32'(vga_hsync));
        check_val("first_vsync", 32'd1, 32'(vga_vsync));
        check_val("first_rgb", 32'h0, 32'({vga_r, vga_g, vga_b}));
        for (i = 0; i < names.size(); i++) begin
            target = frames[i] * FRAME_LEN + ys[i] * LINE_W + xs[i] + 2;
            if (target <= edge_cnt) begin
                $display("table entry %s is not in raster order", names[i]);
                $display("Simulation FAILED");
                $fatal(1, "bad stimulus table");
            end
            while (edge_cnt < target) @(negedge clk_pix);
            exp_rgb = expected_colour(frames[i], xs[i], ys[i]);
            check_val({names[i], "_rgb"}, 32'(exp_rgb), 32'({vga_r, vga_g, vga_b}));
            check_val({names[i], "_hsync"}, 32'(!(xs[i] >= 36 && xs[i] < 40)),
                      32'(vga_hsync));
            check_val({names[i], "_vsync"}, 32'(!(ys[i] >= 26 && ys[i] < 28)),
                      32'(vga_vsync));
        end
        $display("Simulation PASSED");
        $finish;
    end

    // last table frame plus two spare frames, plus reset
    initial begin
        int limit;
        wait (table_ready);
        limit = (frames[frames.size() - 1] + 3) * FRAME_LEN + 20;
        #(limit * 20);
        $display("timeout: the table entries were not reached in time");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tests/tb_clock.sv */
// free-running pixel clock for the testbench

module tb_clock #(
    parameter int PERIOD = 20  // time units per cycle
) (
    output logic clk_pix
);

    initial clk_pix = 1'b0;

    always #(PERIOD / 2) clk_pix = ~clk_pix;  // 50% duty

endmodule
